// File: flist.f
design/l1_cache_pkg.sv
design/line_store.sv
design/tag_lookup.sv
design/cache_ctrl.sv
design/l1_cache.sv
tb/tb_clock.sv
tb/mem_model.sv
tb/l1_cache_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= l1_cache_tb
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
PASS_STR  ?= *** PASSED ***

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) --Mdir $(OBJ_DIR)

# the run passes only if the pass line shows up in the output
run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_STR)'

clean:
	rm -rf $(OBJ_DIR)

// File: tb/l1_cache_tb.sv
`timescale 1ns/1ps

module l1_cache_tb;
    import l1_cache_pkg::*;

    localparam int WAIT_LIMIT  = 100;   // cycles for one processor access
    localparam int FLUSH_LIMIT = 1000;  // cycles for a whole sweep

    logic       CLK, nRST;
    logic       flush, flush_done;
    proc_req_t  proc_req;
    proc_resp_t proc_resp;
    mem_req_t   mem_req;
    mem_resp_t  mem_resp;

    word_t shadow [word_t];  // expected memory of written words only
    word_t wb_addr [$];      // accepted write beats
    word_t wb_data [$];
    int    waited;           // busy cycles of the last access

    tb_clock  u_clk (.CLK, .nRST);
    mem_model u_mem (.CLK, .nRST, .mem_req, .mem_resp);

    l1_cache UUT (
        .CLK, .nRST, .proc_req, .proc_resp, .mem_resp, .mem_req, .flush, .flush_done
    );

    task automatic fail_stop(input string why);
        $display("%s", why);
        $display("*** FAILED ***");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        assert (got === exp)
            else fail_stop($sformatf("CHECK FAILED at %0t: %s = %h, expected %h",
                                     $time, name, got, exp));
    endtask

    // untouched words read back as their address inverted
    function automatic word_t expected_word(input word_t addr);
        return shadow.exists(addr) ? shadow[addr] : ~addr;
    endfunction

    // request held until busy drops
    task automatic access(input logic wr, input word_t addr, input word_t wdata,
                          output word_t got, output int cycles);
        logic done;
        done           = 1'b0;
        cycles         = 0;
        proc_req.ren   = !wr;
        proc_req.wen   = wr;
        proc_req.addr  = addr;
        proc_req.wdata = wdata;
        while (!done) begin
            @(negedge CLK);  // sampled at the falling edge
            if (!proc_resp.busy) begin
                done = 1'b1;
                got  = proc_resp.rdata;
            end else begin
                cycles++;
                if (cycles > WAIT_LIMIT) fail_stop("timeout: cache kept the processor busy");
                @(posedge CLK);
                #1;
            end
        end
        @(posedge CLK);  // write commits on this edge
        #1;
        proc_req.ren = 1'b0;
        proc_req.wen = 1'b0;
        if (wr) shadow[addr] = wdata;
    endtask

    task automatic write_word(input word_t addr, input word_t data);
        word_t unused;
        int    cycles;
        access(1'b1, addr, data, unused, cycles);
    endtask

    task automatic read_check(input word_t addr, output int cycles);
        word_t got;
        access(1'b0, addr, '0, got, cycles);
        check_word("proc_resp.rdata", got, expected_word(addr));
    endtask

    // beats since the last clear form exactly the line at base
    task automatic check_wb_line(input word_t base);
        assert (wb_addr.size() == BLOCK_SIZE)
            else fail_stop("write-back did not carry exactly one line");
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            check_word("mem_req.addr", wb_addr[i], base + word_t'(4 * i));
            check_word("mem_req.wdata", wb_data[i], expected_word(base + word_t'(4 * i)));
        end
    endtask

    task automatic run_flush();
        int cycles;
        cycles = 0;
        flush  = 1'b1;  // level held until done
        @(negedge CLK);
        while (!flush_done) begin
            cycles++;
            if (cycles > FLUSH_LIMIT) fail_stop("timeout: flush_done never came");
            @(negedge CLK);
        end
        @(posedge CLK);
        #1;
        flush = 1'b0;
        @(negedge CLK);
        check_word("flush_done", word_t'(flush_done), '0);  // gone after one cycle
        @(posedge CLK);
        #1;
    endtask

    always @(negedge CLK) begin
        if (nRST && mem_req.wen && !mem_resp.busy) begin
            wb_addr.push_back(mem_req.addr);
            wb_data.push_back(mem_req.wdata);
        end
    end

    a_mem_one_dir: assert property (@(negedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen)) else fail_stop("memory ren and wen were high together");

    a_done_pulse: assert property (@(negedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done) else fail_stop("flush_done lasted more than one cycle");

    initial begin
        int w;
        proc_req = '0;
        flush    = 1'b0;
        w        = 0;
        while (nRST !== 1'b1) begin
            w++;
            if (w > 20) fail_stop("timeout: reset was never released");
            @(posedge CLK);
        end
        @(posedge CLK);
        #1;

        read_check(32'h0000_0100, waited);  // cold miss
        write_word(32'h0000_0040, 32'hCAFE_0040);
        read_check(32'h0000_0040, waited);
        read_check(32'h0000_0040, waited);  // now a hit
        check_word("hit wait cycles", word_t'(waited), '0);

        // in set 5 C pushes out the older line A
        write_word(32'h0000_0228, 32'hAAAA_0228);
        write_word(32'h0000_042C, 32'hBBBB_042C);
        wb_addr.delete();
        wb_data.delete();
        read_check(32'h0000_0628, waited);
        check_wb_line(32'h0000_0228);
        read_check(32'h0000_0228, waited);  // refetched from memory

        // in set 9 touching A again leaves B as the victim
        write_word(32'h0000_024C, 32'h1111_024C);
        write_word(32'h0000_0448, 32'h2222_0448);
        read_check(32'h0000_024C, waited);
        wb_addr.delete();
        wb_data.delete();
        read_check(32'h0000_0648, waited);
        check_wb_line(32'h0000_0448);

        // more dirty lines then flush them all
        write_word(32'h0000_00A0, 32'h3333_00A0);
        write_word(32'h0000_00A4, 32'h4444_00A4);
        write_word(32'h0000_03F8, 32'h5555_03F8);  // last set of the sweep
        write_word(32'h0000_0840, 32'h6666_0840);  // way 0 of set 8
        write_word(32'h0000_0044, 32'h7777_0044);  // way 1 of set 8
        run_flush();
        foreach (shadow[a]) begin
            check_word("mem_model word", u_mem.mem[a[11:2]], shadow[a]);
        end

        $display("*** PASSED ***");
        $finish;
    end

endmodule

// File: tb/mem_model.sv
`timescale 1ns/1ps

module mem_model (
    input  logic                    CLK,
    input  logic                    nRST,
    input  l1_cache_pkg::mem_req_t  mem_req,
    output l1_cache_pkg::mem_resp_t mem_resp
);
    import l1_cache_pkg::*;

    localparam int MEM_WORDS = 1024;  // 4 KiB behind the port

    word_t       mem [MEM_WORDS];
    logic [15:0] lfsr, lfsr_mid, lfsr_next;
    logic [1:0]  wait_left;  // busy cycles still owed on this beat
    logic [1:0]  draw;
    logic        active;
    logic [9:0]  idx;

    // galois form, taps 16 14 13 11
    function automatic logic [15:0] lfsr_step(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    initial begin
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i] <= ~word_t'(i * 4);  // untouched word = its address inverted
        end
    end

    assign active = mem_req.ren | mem_req.wen;
    assign idx    = mem_req.addr[11:2];  // word index, byte bits dropped

    // two bits per draw, one step per bit
    assign lfsr_mid  = lfsr_step(lfsr);
    assign lfsr_next = lfsr_step(lfsr_mid);
    assign draw      = {lfsr[0], lfsr_mid[0]};

    assign mem_resp = '{busy: active && (wait_left != 2'd0), rdata: mem[idx]};

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            lfsr      <= 16'd44;  // seed
            wait_left <= '0;
        end else if (active) begin
            if (wait_left != 2'd0) begin
                wait_left <= wait_left - 1'b1;
            end else begin
                // beat taken, pick the wait for the next one
                wait_left <= draw;
                lfsr      <= lfsr_next;
            end
        end
    end

    always @(posedge CLK) begin
        if (nRST && mem_req.wen && !mem_resp.busy) begin
            mem[idx] <= mem_req.wdata;  // write-back word lands
        end
    end

endmodule

// File: tb/tb_clock.sv
`timescale 1ns/1ps

module tb_clock (
    output logic CLK,
    output logic nRST
);
    initial CLK = 1'b0;
    always #20 CLK = ~CLK;  // 40 ns period

    // reset low for the first 5 rising edges
    initial begin
        nRST = 1'b0;
        repeat (5) @(posedge CLK);
        #1 nRST = 1'b1;  // released just after the edge
    end

endmodule

// File: design/l1_cache.sv
`timescale 1ns/1ps

module l1_cache (
    input  logic                     CLK,
    input  logic                     nRST,
    input  l1_cache_pkg::proc_req_t  proc_req,
    output l1_cache_pkg::proc_resp_t proc_resp,
    input  l1_cache_pkg::mem_resp_t  mem_resp,
    output l1_cache_pkg::mem_req_t   mem_req,
    input  logic                     flush,
    output logic                     flush_done
);
    import l1_cache_pkg::*;

    // lookup results
    logic                  hit, victim_dirty, sweep_dirty;
    way_t                  hit_way, victim_way;
    logic [N_TAG_BITS-1:0] victim_tag;

    // update strobes and shared frame select
    logic                    tag_wr, tag_set_dirty, tag_clr_dirty, lru_touch;
    way_t                    op_way;
    logic [N_SET_BITS-1:0]   op_set;

    // data port
    logic                    line_wr;
    logic [N_BLOCK_BITS-1:0] line_word;
    word_t                   line_wdata, rd_word;

    cache_ctrl u_ctrl (
        .CLK, .nRST, .proc_req, .mem_resp, .flush,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .sweep_dirty, .rd_word,
        .proc_resp, .mem_req, .flush_done,
        .tag_wr, .tag_set_dirty, .tag_clr_dirty, .lru_touch,
        .op_way, .op_set, .line_wr, .line_word, .line_wdata
    );

    tag_lookup u_tags (
        .CLK, .nRST,
        .lookup_addr (proc_req.addr),   // always the processor address
        .tag_wr, .tag_set_dirty, .tag_clr_dirty, .lru_touch, .op_way, .op_set,
        .hit, .hit_way, .victim_way, .victim_dirty, .victim_tag, .sweep_dirty
    );

    line_store u_data (
        .CLK, .nRST, .line_wr, .op_way, .op_set, .line_word, .line_wdata, .rd_word
    );

endmodule

// File: design/cache_ctrl.sv
`timescale 1ns/1ps

module cache_ctrl (
    input  logic                                  CLK,
    input  logic                                  nRST,
    input  l1_cache_pkg::proc_req_t               proc_req,
    input  l1_cache_pkg::mem_resp_t               mem_resp,
    input  logic                                  flush,
    input  logic                                  hit,
    input  l1_cache_pkg::way_t                    hit_way,
    input  l1_cache_pkg::way_t                    victim_way,
    input  logic                                  victim_dirty,
    input  logic [l1_cache_pkg::N_TAG_BITS-1:0]   victim_tag,
    input  logic                                  sweep_dirty,
    input  l1_cache_pkg::word_t                   rd_word,
    output l1_cache_pkg::proc_resp_t              proc_resp,
    output l1_cache_pkg::mem_req_t                mem_req,
    output logic                                  flush_done,
    output logic                                  tag_wr,
    output logic                                  tag_set_dirty,
    output logic                                  tag_clr_dirty,
    output logic                                  lru_touch,
    output l1_cache_pkg::way_t                    op_way,
    output logic [l1_cache_pkg::N_SET_BITS-1:0]   op_set,
    output logic                                  line_wr,
    output logic [l1_cache_pkg::N_BLOCK_BITS-1:0] line_word,
    output l1_cache_pkg::word_t                   line_wdata
);
    import l1_cache_pkg::*;

    cache_state_t          state, next_state;
    logic [N_BLOCK_BITS:0] word_cnt;    // counts up to BLOCK_SIZE
    logic [N_SET_BITS:0]   set_cnt;     // top bit marks end of sweep
    way_t                  way_cnt;
    addr_t                 req_addr;
    logic                  req;         // processor access pending
    logic                  word_done;   // closing cycle of a beat state
    logic                  set_done;
    logic                  beat;        // word accepted by memory

    assign req_addr  = proc_req.addr;
    assign req       = proc_req.ren | proc_req.wen;
    assign word_done = (word_cnt == BLOCK_SIZE);
    assign set_done  = (set_cnt == N_SETS);
    assign beat      = (mem_req.ren | mem_req.wen) & ~mem_resp.busy;

    always_comb begin
        next_state      = state;
        proc_resp.busy  = 1'b1;
        proc_resp.rdata = rd_word;
        mem_req.ren     = 1'b0;
        mem_req.wen     = 1'b0;
        mem_req.wdata   = rd_word;   // write-back data straight from the array
        mem_req.addr    = {victim_tag, req_addr.set, word_cnt[N_BLOCK_BITS-1:0], 2'b00};
        flush_done      = 1'b0;
        tag_wr          = 1'b0;
        tag_set_dirty   = 1'b0;
        tag_clr_dirty   = 1'b0;
        lru_touch       = 1'b0;
        line_wr         = 1'b0;
        op_way          = hit_way;
        op_set          = req_addr.set;
        line_word       = req_addr.word;
        line_wdata      = proc_req.wdata;

        case (state)
            IDLE: begin
                if (req && hit) begin  // answered this cycle
                    proc_resp.busy = 1'b0;
                    lru_touch      = 1'b1;
                    if (proc_req.wen) begin
                        line_wr       = 1'b1;
                        tag_set_dirty = 1'b1;
                    end
                end else if (req) begin
                    next_state = victim_dirty ? WB : FETCH;
                end else if (flush) begin  // only with no request waiting
                    next_state = FLUSH_SWEEP;
                end
            end
            WB: begin
                op_way    = victim_way;
                line_word = word_cnt[N_BLOCK_BITS-1:0];
                if (word_done) begin
                    tag_clr_dirty = 1'b1;
                    next_state    = FETCH;
                end else begin
                    mem_req.wen = 1'b1;
                end
            end
            FETCH: begin
                op_way       = victim_way;
                line_word    = word_cnt[N_BLOCK_BITS-1:0];
                line_wdata   = mem_resp.rdata;
                mem_req.addr = {req_addr.tag, req_addr.set, word_cnt[N_BLOCK_BITS-1:0], 2'b00};
                if (word_done) begin
                    tag_wr     = 1'b1;   // line complete, retry as a hit
                    next_state = IDLE;
                end else begin
                    mem_req.ren = 1'b1;
                    line_wr     = ~mem_resp.busy;
                end
            end
            FLUSH_SWEEP: begin
                op_way = way_cnt;
                op_set = set_cnt[N_SET_BITS-1:0];
                if (set_done) begin
                    flush_done = 1'b1;
                    next_state = IDLE;
                end else if (sweep_dirty) begin
                    next_state = FLUSH_WB;
                end
            end
            FLUSH_WB: begin
                op_way       = way_cnt;
                op_set       = set_cnt[N_SET_BITS-1:0];
                line_word    = word_cnt[N_BLOCK_BITS-1:0];
                mem_req.addr = {victim_tag, set_cnt[N_SET_BITS-1:0],
                                word_cnt[N_BLOCK_BITS-1:0], 2'b00};
                if (word_done) begin
                    tag_clr_dirty = 1'b1;   // sweep then moves past this frame
                    next_state    = FLUSH_SWEEP;
                end else begin
                    mem_req.wen = 1'b1;
                end
            end
            default: next_state = IDLE;
        endcase
    end

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            state    <= IDLE;
            word_cnt <= '0;
            set_cnt  <= '0;
            way_cnt  <= '0;
        end else begin
            state <= next_state;
            // stalls on memory busy, so the address holds too
            if (word_done)  word_cnt <= '0;
            else if (beat)  word_cnt <= word_cnt + 1'b1;
            if (state == IDLE) begin  // every flush starts at set 0, way 0
                set_cnt <= '0;
                way_cnt <= '0;
            end else if (state == FLUSH_SWEEP && !set_done && !sweep_dirty) begin
                way_cnt <= way_cnt + 1'b1;
                if (way_cnt == way_t'(ASSOC - 1)) set_cnt <= set_cnt + 1'b1;
            end
        end
    end

    a_no_rd_wr: assert property (@(posedge CLK) disable iff (!nRST)
        !(mem_req.ren && mem_req.wen)) else $error("cache_ctrl: ren and wen together");

    a_done_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        flush_done |=> !flush_done) else $error("cache_ctrl: flush_done held");

endmodule

// File: design/tag_lookup.sv
`timescale 1ns/1ps

module tag_lookup (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  l1_cache_pkg::addr_t                  lookup_addr,   // processor address
    input  logic                                 tag_wr,        // install tag, mark valid
    input  logic                                 tag_set_dirty,
    input  logic                                 tag_clr_dirty,
    input  logic                                 lru_touch,
    input  l1_cache_pkg::way_t                   op_way,
    input  logic [l1_cache_pkg::N_SET_BITS-1:0]  op_set,
    output logic                                 hit,
    output l1_cache_pkg::way_t                   hit_way,
    output l1_cache_pkg::way_t                   victim_way,
    output logic                                 victim_dirty,
    output logic [l1_cache_pkg::N_TAG_BITS-1:0]  victim_tag,
    output logic                                 sweep_dirty
);
    import l1_cache_pkg::*;

    logic                  valid [N_SETS][ASSOC];
    logic                  dirty [N_SETS][ASSOC];
    logic [N_TAG_BITS-1:0] tags  [N_SETS][ASSOC];
    way_t                  lru   [N_SETS];      // last used way of each set
    logic [ASSOC-1:0]      match;               // per way tag compare

    // compare both ways of the addressed set
    always_comb begin
        hit_way = '0;
        for (int w = 0; w < ASSOC; w++) begin
            match[w] = valid[lookup_addr.set][w] && (tags[lookup_addr.set][w] == lookup_addr.tag);
            if (match[w]) begin
                hit_way = way_t'(w);
            end
        end
    end

    assign hit = |match;

    // replace the way not used last
    assign victim_way   = ~lru[lookup_addr.set];
    assign victim_dirty = valid[lookup_addr.set][victim_way] & dirty[lookup_addr.set][victim_way];

    // frame picked by the controller
    // the victim during WB, the swept frame during flush
    assign victim_tag  = tags[op_set][op_way];
    assign sweep_dirty = valid[op_set][op_way] & dirty[op_set][op_way];

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            valid <= '{default: 1'b0};
            dirty <= '{default: 1'b0};
            tags  <= '{default: '0};
            lru   <= '{default: '0};
        end else begin
            if (tag_wr) begin  // fetch finished, new line is clean
                valid[op_set][op_way] <= 1'b1;
                tags[op_set][op_way]  <= lookup_addr.tag;
                dirty[op_set][op_way] <= 1'b0;
            end
            if (tag_set_dirty) dirty[op_set][op_way] <= 1'b1;   // write hit
            if (tag_clr_dirty) dirty[op_set][op_way] <= 1'b0;   // after write-back
            if (lru_touch)     lru[op_set] <= op_way;
        end
    end

    // a line is never installed twice in one set
    a_one_way_hits: assert property (@(posedge CLK) disable iff (!nRST) $onehot0(match))
        else $error("tag_lookup: both ways hit");

endmodule

// File: design/line_store.sv
`timescale 1ns/1ps

module line_store (
    input  logic                                 CLK,
    input  logic                                 nRST,
    input  logic                                 line_wr,
    input  l1_cache_pkg::way_t                   op_way,
    input  logic [l1_cache_pkg::N_SET_BITS-1:0]  op_set,
    input  logic [l1_cache_pkg::N_BLOCK_BITS-1:0] line_word,
    input  l1_cache_pkg::word_t                  line_wdata,
    output l1_cache_pkg::word_t                  rd_word
);
    import l1_cache_pkg::*;

    // block data, set by way by word
    word_t data [N_SETS][ASSOC][BLOCK_SIZE];

    // one addressed word port
    // hit reads, write-back reads and fetch writes all share it
    assign rd_word = data[op_set][op_way][line_word];  // combinational read

    always_ff @(posedge CLK or negedge nRST) begin
        if (!nRST) begin
            data <= '{default: '0};  // whole array starts clear
        end else if (line_wr) begin
            // processor write hit or one fetched word
            data[op_set][op_way][line_word] <= line_wdata;
        end
    end

endmodule

// File: design/l1_cache_pkg.sv
package l1_cache_pkg;

    // geometry of the one supported configuration
    localparam int WORD_SIZE    = 32;    // bits per data word
    localparam int CACHE_SIZE   = 1024;  // capacity in bytes
    localparam int BLOCK_SIZE   = 2;     // words per line
    localparam int ASSOC        = 2;     // ways per set

    // derived sizes
    localparam int N_SETS       = CACHE_SIZE / (BLOCK_SIZE * (WORD_SIZE / 8) * ASSOC);
    localparam int N_SET_BITS   = $clog2(N_SETS);        // 6
    localparam int N_BLOCK_BITS = $clog2(BLOCK_SIZE);    // 1
    localparam int N_TAG_BITS   = WORD_SIZE - N_SET_BITS - N_BLOCK_BITS - 2;  // 23

    typedef logic [WORD_SIZE-1:0] word_t;

    // byte address split into cache fields
    typedef struct packed {
        logic [N_TAG_BITS-1:0]   tag;
        logic [N_SET_BITS-1:0]   set;
        logic [N_BLOCK_BITS-1:0] word;      // word within the line
        logic [1:0]              byte_off;  // always ignored, full word access
    } addr_t;

    typedef logic [$clog2(ASSOC)-1:0] way_t;

    // processor side
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } proc_req_t;

    typedef struct packed {
        logic  busy;   // low only while a hit is answered
        word_t rdata;
    } proc_resp_t;

    // memory side, one word per accepted beat
    typedef struct packed {
        logic  ren;
        logic  wen;
        word_t addr;
        word_t wdata;
    } mem_req_t;

    typedef struct packed {
        logic  busy;   // high stalls the current beat
        word_t rdata;
    } mem_resp_t;

    // controller states
    typedef enum logic [2:0] {
        IDLE,          // answer hits, pick miss or flush
        WB,            // write dirty victim back
        FETCH,         // fill victim frame from memory
        FLUSH_SWEEP,   // walk every set and way
        FLUSH_WB       // write one dirty frame back
    } cache_state_t;

endpackage
